// ==== source/sa_pkg.sv ====
// Attention engine shared definitions
`default_nettype none

package sa_pkg;

	// ====================
	// sizes
	// ====================

	// features per token and weight matrix side
	localparam int DIM = 8;
	// largest token count in a frame
	localparam int MAX_TOKENS = 8;
	// in_valid length of one input frame
	localparam int LOAD_CYCLES = 192;

	localparam int IN_W = 8;
	// 8 products of 8x8 bits, plus the carry into bit 17
	localparam int PROJ_W = 19;
	// 8 products of 19x19 bits
	localparam int SCORE_W = 41;
	localparam int OUT_W = 64;

	// load counter, wide enough for LOAD_CYCLES
	localparam int CNT_W = 8;
	// token count field, holds 1..8
	localparam int TOK_W = 4;
	// row and column index into an 8-wide matrix
	localparam int IDX_W = 3;
	// scaling divisor applied to each raw score
	localparam int SCORE_DIV = 3;

	// ====================
	// data types
	// ====================

	typedef logic signed [IN_W-1:0] elem_t;
	typedef logic signed [PROJ_W-1:0] proj_t;
	typedef logic signed [SCORE_W-1:0] score_t;
	typedef logic signed [OUT_W-1:0] out_t;

	// [row][col], X and the three weight matrices
	typedef elem_t [DIM-1:0][DIM-1:0] mat_t;
	// [token][feature], one Q, K or V matrix
	typedef proj_t [MAX_TOKENS-1:0][DIM-1:0] pmat_t;

	// decode to execute, all weights held row-major
	typedef struct packed {
		logic [TOK_W-1:0] tokens;
		mat_t x;
		mat_t wq;
		mat_t wk;
		mat_t wv;
	} frame_t;

	// execute to result
	typedef struct packed {
		logic [TOK_W-1:0] tokens;
		pmat_t q;
		pmat_t k;
		pmat_t v;
	} proj_set_t;

endpackage

`default_nettype wire

// ==== source/sa_load.sv ====
// Frame load stage
`timescale 1ns/10ps
`default_nettype none

module sa_load import sa_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid,
	input wire logic [TOK_W-1:0] t,
	input wire elem_t in_data,
	input wire elem_t w_q,
	input wire elem_t w_k,
	input wire elem_t w_v,
	input wire logic busy,
	output frame_t frame,
	output logic frame_start
);

	// ====================
	// control
	// ====================

	logic [CNT_W-1:0] cnt;
	logic loading;
	// burst seen but not loaded, wait for in_valid to drop
	logic hold;
	logic in_valid_q;
	logic t_ok;
	logic first;
	logic start;
	logic take;
	logic [TOK_W-1:0] tok_now;

	// only T = 1, 4 or 8 is a legal frame
	assign t_ok = (t == TOK_W'(1)) || (t == TOK_W'(4)) || (t == TOK_W'(MAX_TOKENS));

	// first cycle of a burst while nothing else is going on
	assign first = in_valid && !loading && !hold;
	// engine idle, in_valid was low last cycle, and T is legal
	assign start = first && !in_valid_q && !busy && t_ok;
	// cycles whose inputs are stored
	assign take = start || (loading && in_valid);
	// T is not registered yet on the first cycle
	assign tok_now = start ? t : frame.tokens;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			loading <= 1'b0;
			hold <= 1'b0;
			in_valid_q <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			in_valid_q <= in_valid;
			frame_start <= 1'b0;
			if (first) begin
				if (start) begin
					loading <= 1'b1;
					cnt <= CNT_W'(1);
				end else begin
					// rejected burst, ignored whole
					hold <= 1'b1;
				end
			end else if (loading) begin
				if (!in_valid) begin
					// burst cut short, drop it
					loading <= 1'b0;
					cnt <= '0;
				end else if (cnt == CNT_W'(LOAD_CYCLES - 1)) begin
					loading <= 1'b0;
					hold <= 1'b1;
					cnt <= '0;
					frame_start <= 1'b1;
				end else begin
					cnt <= cnt + CNT_W'(1);
				end
			end else if (hold && !in_valid) begin
				hold <= 1'b0;
			end
		end
	end

	// ====================
	// element steering
	// ====================

	// cnt[7:6] picks the matrix, cnt[5:3] and cnt[2:0] the element
	always_ff @(posedge clk) begin
		if (start) begin
			frame.tokens <= t;
		end
		if (take) begin
			case (cnt[7:6])
				2'd0: begin
					frame.wq[cnt[5:3]][cnt[2:0]] <= w_q;
					// X only for the first T rows
					if ({1'b0, cnt[5:3]} < tok_now) begin
						frame.x[cnt[5:3]][cnt[2:0]] <= in_data;
					end
				end
				// Wk arrives column-major, store it back row-major
				2'd1: frame.wk[cnt[2:0]][cnt[5:3]] <= w_k;
				2'd2: frame.wv[cnt[5:3]][cnt[2:0]] <= w_v;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/sa_project.sv ====
// Q, K and V projection stage
`timescale 1ns/10ps
`default_nettype none

module sa_project import sa_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire frame_t frame,
	input wire logic frame_start,
	output proj_set_t proj,
	output logic proj_start
);

	// ====================
	// row walk
	// ====================

	logic running;
	logic [IDX_W-1:0] row;
	logic [IDX_W-1:0] row_last;

	// index of the last token row
	assign row_last = IDX_W'(frame.tokens - TOK_W'(1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			row <= '0;
			proj_start <= 1'b0;
		end else begin
			proj_start <= 1'b0;
			if (frame_start) begin
				running <= 1'b1;
				row <= '0;
			end else if (running) begin
				if (row == row_last) begin
					running <= 1'b0;
					// Q, K and V all done after this write
					proj_start <= 1'b1;
				end else begin
					row <= row + IDX_W'(1);
				end
			end
		end
	end

	// ====================
	// multiply-add trees
	// ====================

	// one element of X*W: row r of X against column c of W
	function automatic proj_t mac_col(
		input mat_t x,
		input mat_t w,
		input logic [IDX_W-1:0] r,
		input int c
	);
		proj_t acc;
		int k;
		acc = '0;
		for (k = 0; k < DIM; k++) begin
			// signed 8x8 products widen to PROJ_W in the sum
			acc = acc + $signed(x[r][k]) * $signed(w[k][c]);
		end
		return acc;
	endfunction

	proj_t [DIM-1:0] q_row;
	proj_t [DIM-1:0] k_row;
	proj_t [DIM-1:0] v_row;

	// three banks of eight trees, one full row of each per cycle
	always_comb begin
		for (int c = 0; c < DIM; c++) begin
			q_row[c] = mac_col(frame.x, frame.wq, row, c);
			k_row[c] = mac_col(frame.x, frame.wk, row, c);
			v_row[c] = mac_col(frame.x, frame.wv, row, c);
		end
	end

	// ====================
	// projection store
	// ====================

	// cleared at frame_start so rows T..7 stay zero
	always_ff @(posedge clk) begin
		if (frame_start) begin
			proj.tokens <= frame.tokens;
			proj.q <= '0;
			proj.k <= '0;
			proj.v <= '0;
		end else if (running) begin
			proj.q[row] <= q_row;
			proj.k[row] <= k_row;
			proj.v[row] <= v_row;
		end
	end

endmodule

`default_nettype wire

// ==== source/sa_attend.sv ====
// Score and output stage
`timescale 1ns/10ps
`default_nettype none

module sa_attend import sa_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire proj_set_t proj,
	input wire logic proj_start,
	output logic busy,
	output logic out_valid,
	output out_t out_data
);

	// ====================
	// phase control
	// ====================

	logic scoring;
	logic emitting;
	// score phase: i is the Q row, j the K row
	// output phase: i is the result row, j the column
	logic [IDX_W-1:0] i;
	logic [IDX_W-1:0] j;
	logic [IDX_W-1:0] tok_last;

	assign tok_last = IDX_W'(proj.tokens - TOK_W'(1));

	// held through the last registered word
	assign busy = proj_start || scoring || emitting || out_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scoring <= 1'b0;
			emitting <= 1'b0;
			i <= '0;
			j <= '0;
		end else if (proj_start) begin
			scoring <= 1'b1;
			emitting <= 1'b0;
			i <= '0;
			j <= '0;
		end else if (scoring) begin
			// T x T entries, one per cycle
			if (j == tok_last) begin
				j <= '0;
				if (i == tok_last) begin
					scoring <= 1'b0;
					emitting <= 1'b1;
					i <= '0;
				end else begin
					i <= i + IDX_W'(1);
				end
			end else begin
				j <= j + IDX_W'(1);
			end
		end else if (emitting) begin
			// T x 8 words, row by row
			if (j == IDX_W'(DIM - 1)) begin
				j <= '0;
				if (i == tok_last) begin
					emitting <= 1'b0;
					i <= '0;
				end else begin
					i <= i + IDX_W'(1);
				end
			end else begin
				j <= j + IDX_W'(1);
			end
		end
	end

	// ====================
	// scores
	// ====================

	// Q row a dot K row b, divided and clamped
	function automatic score_t qk_score(
		input pmat_t q,
		input pmat_t k,
		input logic [IDX_W-1:0] a,
		input logic [IDX_W-1:0] b
	);
		score_t acc;
		score_t quo;
		int n;
		acc = '0;
		for (n = 0; n < DIM; n++) begin
			acc = acc + $signed(q[a][n]) * $signed(k[b][n]);
		end
		// signed divide truncates toward zero
		quo = acc / SCORE_DIV;
		// negative scores become zero
		return quo[SCORE_W-1] ? score_t'(0) : quo;
	endfunction

	score_t score_now;
	score_t s_bank [MAX_TOKENS][MAX_TOKENS];

	assign score_now = qk_score(proj.q, proj.k, i, j);

	always_ff @(posedge clk) begin
		if (scoring) begin
			s_bank[i][j] <= score_now;
		end
	end

	// ====================
	// S*V output
	// ====================

	out_t word_now;

	// sum over the first T score columns only, the rest of the bank is stale
	always_comb begin
		word_now = '0;
		for (int n = 0; n < MAX_TOKENS; n++) begin
			if (n < proj.tokens) begin
				word_now = word_now + $signed(s_bank[i][n]) * $signed(proj.v[n][j]);
			end
		end
	end

	// one register stage, data forced to zero between words
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data <= '0;
		end else begin
			out_valid <= emitting;
			out_data <= emitting ? word_now : out_t'(0);
		end
	end

endmodule

`default_nettype wire

// ==== source/sa_top.sv ====
// Self-attention engine top
`timescale 1ns/10ps
`default_nettype none

module sa_top import sa_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid,
	input wire logic [TOK_W-1:0] t,
	input wire elem_t in_data,
	input wire elem_t w_q,
	input wire elem_t w_k,
	input wire elem_t w_v,
	output logic out_valid,
	output out_t out_data
);

	// decode to execute
	frame_t frame;
	logic frame_start;
	// execute to result
	proj_set_t proj;
	logic proj_start;
	// result stage running, blocks new frames
	logic busy;

	sa_load i_sa_load (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.t           (t),
		.in_data     (in_data),
		.w_q         (w_q),
		.w_k         (w_k),
		.w_v         (w_v),
		.busy        (busy),
		.frame       (frame),
		.frame_start (frame_start)
	);

	sa_project i_sa_project (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame       (frame),
		.frame_start (frame_start),
		.proj        (proj),
		.proj_start  (proj_start)
	);

	sa_attend i_sa_attend (
		.clk        (clk),
		.rst_n      (rst_n),
		.proj       (proj),
		.proj_start (proj_start),
		.busy       (busy),
		.out_valid  (out_valid),
		.out_data   (out_data)
	);

endmodule

`default_nettype wire

// ==== tb/sa_clock.sv ====
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module sa_clock #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release just after an edge, away from the flops
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/sa_assert.sv ====
// Output protocol assertions
`timescale 1ns/10ps
`default_nettype none

module sa_assert import sa_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid,
	input wire logic out_valid,
	input wire out_t out_data
);

	// no result word can leave during reset
	reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high while rst_n is low");

	// a result burst never overlaps an input frame
	no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(out_valid && in_valid))
		else $error("out_valid and in_valid high in the same cycle");

	// idle data bus is held at zero
	idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> (out_data == '0))
		else $error("out_data not zero while out_valid is low");

endmodule

bind sa_top sa_assert i_sa_assert (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.out_data  (out_data)
);

`default_nettype wire

// ==== tb/sa_tb.sv ====
// Attention engine testbench
`timescale 1ns/10ps
`default_nettype none

module sa_tb import sa_pkg::*; ();

	// ====================
	// constants
	// ====================

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam logic [16:0] LFSR_SEED = 17'd92400;
	localparam int TIMEOUT_MARGIN = 50;
	// inputs change this long after the rising edge
	localparam int DRIVE_DELAY = 1;
	// idle cycles between frames
	localparam int IDLE_GAP = 2;
	// cycles watched for silence after a rejected frame
	localparam int REJECT_WATCH = 40;

	localparam int MODE_RAND = 0;
	localparam int MODE_POS = 1;
	localparam int MODE_NEG = 2;
	localparam int MODE_ALT = 3;

	// stimulus table, one entry per case
	localparam int N_CASES = 10;
	string case_name [N_CASES] = '{"rand_t8", "rand_t4", "rand_t1", "max_pos", "max_neg",
		"alt_sign", "bad_t3", "after_bad", "rand_t8_b", "alt_t4"};
	int case_tokens [N_CASES] = '{8, 4, 1, 8, 8, 8, 3, 4, 8, 4};
	int case_mode [N_CASES] = '{MODE_RAND, MODE_RAND, MODE_RAND, MODE_POS, MODE_NEG,
		MODE_ALT, MODE_RAND, MODE_RAND, MODE_RAND, MODE_ALT};

	// ====================
	// DUT and clock
	// ====================

	logic clk;
	logic rst_n;
	logic in_valid;
	logic [TOK_W-1:0] t;
	elem_t in_data;
	elem_t w_q;
	elem_t w_k;
	elem_t w_v;
	logic out_valid;
	out_t out_data;

	sa_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_sa_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	sa_top i_sa_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.t         (t),
		.in_data   (in_data),
		.w_q       (w_q),
		.w_k       (w_k),
		.w_v       (w_v),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	// ====================
	// stimulus values
	// ====================

	logic [16:0] lfsr_state;
	int err_value;
	int err_frame;
	// current frame, all row-major
	int x_m [DIM][DIM];
	int wq_m [DIM][DIM];
	int wk_m [DIM][DIM];
	int wv_m [DIM][DIM];
	longint exp_words [$];

	// 17-bit Fibonacci LFSR, x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	// one signed byte, one LFSR step per bit
	function automatic int random_elem();
		int v;
		int b;
		v = 0;
		for (b = 0; b < IN_W; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return (v >= 128) ? v - 256 : v;
	endfunction

	// alt mode flips the sign on a checkerboard, so half the scores go negative
	function automatic int make_value(input int mode, input int r, input int c, input int mag);
		case (mode)
			MODE_POS: return 127;
			MODE_NEG: return -128;
			MODE_ALT: return ((r + c) % 2 == 1) ? -mag : mag;
			default: return random_elem();
		endcase
	endfunction

	function automatic bit frame_legal(input int tokens);
		return (tokens == 1) || (tokens == 4) || (tokens == 8);
	endfunction

	task automatic build_frame(input int tokens, input int mode);
		int r;
		int c;
		for (r = 0; r < DIM; r++) begin
			for (c = 0; c < DIM; c++) begin
				x_m[r][c] = (r < tokens) ? make_value(mode, r, c, 100) : 0;
				wq_m[r][c] = make_value(mode, r, c, 90);
				wk_m[r][c] = make_value(mode, r, c, 70);
				wv_m[r][c] = make_value(mode, r, c, 50);
			end
		end
	endtask

	// ====================
	// reference model
	// ====================

	task automatic compute_expected(input int tokens);
		longint q [DIM][DIM];
		longint k [DIM][DIM];
		longint v [DIM][DIM];
		longint s [DIM][DIM];
		longint acc;
		int r;
		int c;
		int n;
		// Q = X*Wq, K = X*Wk, V = X*Wv
		for (r = 0; r < tokens; r++) begin
			for (c = 0; c < DIM; c++) begin
				q[r][c] = 0;
				k[r][c] = 0;
				v[r][c] = 0;
				for (n = 0; n < DIM; n++) begin
					q[r][c] += longint'(x_m[r][n]) * wq_m[n][c];
					k[r][c] += longint'(x_m[r][n]) * wk_m[n][c];
					v[r][c] += longint'(x_m[r][n]) * wv_m[n][c];
				end
			end
		end
		// S = clamp(Q*K^T / 3), truncated toward zero
		for (r = 0; r < tokens; r++) begin
			for (c = 0; c < tokens; c++) begin
				acc = 0;
				for (n = 0; n < DIM; n++) begin
					acc += q[r][n] * k[c][n];
				end
				acc = acc / 3;
				s[r][c] = (acc < 0) ? 0 : acc;
			end
		end
		// S*V, row by row
		exp_words.delete();
		for (r = 0; r < tokens; r++) begin
			for (c = 0; c < DIM; c++) begin
				acc = 0;
				for (n = 0; n < tokens; n++) begin
					acc += s[r][n] * v[n][c];
				end
				exp_words.push_back(acc);
			end
		end
	endtask

	// ====================
	// drive and collect
	// ====================

	task automatic drive_frame(input int tokens);
		int n;
		int m;
		for (n = 0; n < LOAD_CYCLES; n++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			in_valid = 1'b1;
			t = TOK_W'(tokens);
			// filler past the last token row, must be ignored
			in_data = (n < tokens * DIM) ? elem_t'(x_m[n / DIM][n % DIM]) : elem_t'(n * 37);
			w_q = (n < 64) ? elem_t'(wq_m[n / DIM][n % DIM]) : '0;
			m = n - 64;
			// Wk goes in column-major
			w_k = (n >= 64 && n < 128) ? elem_t'(wk_m[m % DIM][m / DIM]) : '0;
			m = n - 128;
			w_v = (n >= 128) ? elem_t'(wv_m[m / DIM][m % DIM]) : '0;
		end
		@(posedge clk);
		#DRIVE_DELAY;
		in_valid = 1'b0;
		in_data = '0;
		w_q = '0;
		w_k = '0;
		w_v = '0;
	endtask

	// outputs are sampled on the falling edge, half a cycle after they change
	task automatic collect_burst(input string name, input int tokens);
		int idx;
		bit in_run;
		in_run = 1'b1;
		@(negedge clk);
		while (!out_valid) @(negedge clk);
		for (idx = 0; idx < tokens * DIM && in_run; idx++) begin
			if (idx > 0) @(negedge clk);
			assert (out_valid) else begin
				$display("%s: output burst stopped after %0d of %0d words",
					name, idx, tokens * DIM);
				err_frame++;
				in_run = 1'b0;
			end
			if (in_run) begin
				assert (out_data == exp_words[idx]) else begin
					$display("[ERROR] %s word %0d: expected %0d, actual %0d",
						name, idx, exp_words[idx], out_data);
					err_value++;
				end
			end
		end
		if (in_run) begin
			@(negedge clk);
			assert (!out_valid) else begin
				$display("%s: extra output word after %0d words", name, tokens * DIM);
				err_frame++;
			end
		end
	endtask

	task automatic watch_silence(input string name, input int cycles);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(negedge clk);
			assert (!out_valid) else begin
				$display("%s: output word seen after a rejected frame", name);
				err_frame++;
			end
		end
	endtask

	// ====================
	// timeout
	// ====================

	int cycle_count = 0;

	function automatic int run_budget();
		int sum;
		int n;
		int tk;
		sum = RESET_CYCLES;
		for (n = 0; n < N_CASES; n++) begin
			tk = case_tokens[n];
			sum += LOAD_CYCLES + 4 * tk + tk * tk + 8 * tk + TIMEOUT_MARGIN;
		end
		return sum;
	endfunction

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= run_budget()) begin
			$display("timeout: run still going after %0d clock cycles", run_budget());
			$display("TEST FAILED");
			$finish;
		end
	end

	// ====================
	// main sequence
	// ====================

	initial begin
		int ci;
		in_valid = 1'b0;
		t = '0;
		in_data = '0;
		w_q = '0;
		w_k = '0;
		w_v = '0;
		lfsr_state = LFSR_SEED;
		err_value = 0;
		err_frame = 0;
		while (rst_n !== 1'b1) @(posedge clk);
		repeat (IDLE_GAP) @(posedge clk);
		for (ci = 0; ci < N_CASES; ci++) begin
			build_frame(case_tokens[ci], case_mode[ci]);
			if (frame_legal(case_tokens[ci])) begin
				compute_expected(case_tokens[ci]);
				drive_frame(case_tokens[ci]);
				collect_burst(case_name[ci], case_tokens[ci]);
			end else begin
				drive_frame(case_tokens[ci]);
				watch_silence(case_name[ci], REJECT_WATCH);
			end
			repeat (IDLE_GAP) @(posedge clk);
		end
		$display("errors: %0d wrong values, %0d framing errors", err_value, err_frame);
		if (err_value == 0 && err_frame == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
source/sa_pkg.sv
source/sa_load.sv
source/sa_project.sv
source/sa_attend.sv
source/sa_top.sv
tb/sa_clock.sv
tb/sa_assert.sv
tb/sa_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the attention engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module sa_tb -f build.f -o sa_sim

status=0
./obj_dir/sa_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TEST PASSED" sim.log; then
	exit 1
fi
